//--- src/uart_pkg.sv
package uart_pkg;

    // ======================================================================
    // APB request and response
    // ======================================================================

    typedef struct packed {
        logic        psel;     // slave selected by the master.
        logic        penable;  // high in the access phase of a transfer.
        logic        pwrite;   // high for a write, low for a read.
        logic [3:0]  paddr;    // byte address within the register block.
        logic [31:0] pwdata;   // write data, only the low byte matters for data.
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;   // read data, valid on the completing cycle.
        logic        pready;   // ends the access phase when high.
        logic        pslverr;  // flags an access to an unknown address.
    } apb_rsp_t;

    // ======================================================================
    // receive path and register map
    // ======================================================================

    typedef struct packed {
        logic [7:0] data;      // received byte, first bit on the line is bit 0.
        logic       frame_err; // stop bit was sampled low.
    } rx_frame_t;

    typedef enum logic [3:0] {
        REG_DATA   = 4'h0,     // tx byte on write, last rx byte on read.
        REG_STATUS = 4'h4,     // ready and sticky flags.
        REG_CTRL   = 4'h8      // loopback enable in bit 0.
    } reg_addr_e;

    localparam int status_tx_ready  = 0; // transmitter can take a byte.
    localparam int status_rx_valid  = 1; // unread byte in the data register.
    localparam int status_overrun   = 2; // a byte was lost before it was read.
    localparam int status_frame_err = 3; // a frame ended with a low stop bit.

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

//--- src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; #(
    parameter int clk_freq  = 125_000_000,
    parameter int baud_rate = 12_500_000
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       tx_valid,
    input  logic [7:0] tx_data,
    output logic       tx_ready,
    output logic       txd
);

    localparam int cycles_per_bit = clk_freq / baud_rate;
    localparam int cnt_w = (cycles_per_bit > 1) ? $clog2(cycles_per_bit) : 1;
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(cycles_per_bit - 1);

    tx_state_e        state;     // position within the frame.
    logic [7:0]       shift_reg; // remaining data bits, next one in bit 0.
    logic [2:0]       bit_idx;   // index of the data bit on the line.
    logic [cnt_w-1:0] wait_cnt;  // cycles spent on the current bit.
    logic             accept;    // byte handed over this cycle.
    logic             bit_done;  // last cycle of the current bit.
    logic             next_bit;  // a data bit goes onto the line this cycle.

    assign accept   = tx_valid && tx_ready;
    assign bit_done = (wait_cnt == last_cnt);
    assign next_bit = bit_done && ((state == TX_START) ||
                                   (state == TX_DATA && bit_idx != 3'd7));

    // ======================================================================
    // data shifter
    // ======================================================================

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_reg <= tx_data;               // latch the byte on the handshake.
        end else if (next_bit) begin
            shift_reg <= shift_reg >> 1;        // lsb first, so shift right.
        end
    end

    // ======================================================================
    // frame state machine
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= TX_IDLE;
            txd      <= 1'b1;                   // line idles high.
            tx_ready <= 1'b0;                   // rises on the first cycle out of reset.
            bit_idx  <= 3'd0;
            wait_cnt <= '0;
        end else begin
            wait_cnt <= (state == TX_IDLE || bit_done) ? '0 : wait_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    tx_ready <= !accept;        // drops for the whole frame.
                    if (accept) begin
                        txd   <= 1'b0;          // start bit.
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        txd     <= shift_reg[0]; // first data bit.
                        bit_idx <= 3'd0;
                        state   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            txd   <= 1'b1;      // stop bit after the eighth bit.
                            state <= TX_STOP;
                        end else begin
                            txd <= shift_reg[0];
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_done) begin
                        tx_ready <= 1'b1;       // single stop bit, then ready again.
                        state    <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

//--- src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; #(
    parameter int clk_freq  = 125_000_000,
    parameter int baud_rate = 12_500_000
) (
    input  logic      clk,
    input  logic      resetn,
    input  logic      rxd,
    output logic      rx_valid,
    output rx_frame_t rx_frame
);

    localparam int cycles_per_bit = clk_freq / baud_rate;
    localparam int cnt_w = (cycles_per_bit > 1) ? $clog2(cycles_per_bit) : 1;
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(cycles_per_bit - 1);
    localparam logic [cnt_w-1:0] half_cnt = cnt_w'(cycles_per_bit / 2 - 1);

    rx_state_e        state;     // position within the frame.
    logic             rxd_meta;  // first synchronizer stage.
    logic             rxd_sync;  // second stage, safe to use in the fsm.
    logic             rxd_last;  // previous synchronized level for edge detection.
    logic [7:0]       shift_reg; // data bits collected so far.
    logic [2:0]       bit_idx;   // number of the data bit sampled next.
    logic [cnt_w-1:0] wait_cnt;  // cycles since the last sample point.
    logic             start_edge;
    logic             half_done;
    logic             bit_done;

    // a frame starts on a falling edge, so a line held low starts at most one frame.
    assign start_edge = rxd_last && !rxd_sync;
    assign half_done  = (wait_cnt == half_cnt);
    assign bit_done   = (wait_cnt == last_cnt);

    // ======================================================================
    // input synchronizer
    // ======================================================================

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rxd_meta <= 1'b1;                   // idle level, no false start.
            rxd_sync <= 1'b1;
            rxd_last <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_last <= rxd_sync;
        end
    end

    // ======================================================================
    // sampling and frame output
    // ======================================================================

    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done) begin
            shift_reg <= {rxd_sync, shift_reg[7:1]}; // lsb arrives first.
        end
        if (state == RX_STOP && bit_done) begin
            rx_frame.data      <= shift_reg;
            rx_frame.frame_err <= !rxd_sync;    // stop bit must read high.
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= RX_IDLE;
            rx_valid <= 1'b0;
            bit_idx  <= 3'd0;
            wait_cnt <= '0;
        end else begin
            rx_valid <= 1'b0;                   // single-cycle pulse by default.
            case (state)
                RX_IDLE: begin
                    wait_cnt <= '0;
                    if (start_edge) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (half_done) begin
                        wait_cnt <= '0;         // next samples fall on bit centers.
                        bit_idx  <= 3'd0;
                        state    <= rxd_sync ? RX_IDLE : RX_DATA; // high here is a glitch.
                    end
                end
                RX_DATA: begin
                    wait_cnt <= bit_done ? '0 : wait_cnt + 1'b1;
                    if (bit_done) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    wait_cnt <= bit_done ? '0 : wait_cnt + 1'b1;
                    if (bit_done) begin
                        rx_valid <= 1'b1;       // frame leaves with the stop sample.
                        state    <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

//--- src/uart_apb_regs.sv
`timescale 1ns/1ps

module uart_apb_regs import uart_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    output logic       tx_valid,
    output logic [7:0] tx_data,
    input  logic       tx_ready,
    input  logic       rx_valid,
    input  rx_frame_t  rx_frame,
    output logic       loopback
);

    logic       access;         // access phase of a transfer.
    logic       addr_ok;        // address is one of the three registers.
    logic       data_wr;        // write to the data register in the access phase.
    logic       data_rd;        // completing read of the data register.
    logic       status_wr;      // completing write to the status register.
    logic       ctrl_wr;        // completing write to the control register.
    logic [7:0] rx_data;        // last received byte.
    logic       stat_rx_valid;  // unread byte held in rx_data.
    logic       stat_overrun;   // sticky, a byte was overwritten unread.
    logic       stat_frame_err; // sticky, a frame ended with a low stop bit.
    logic [3:0] status;

    // ======================================================================
    // address decode and handshake
    // ======================================================================

    assign access = apb_req.psel && apb_req.penable;

    always_comb begin
        case (apb_req.paddr)
            REG_DATA, REG_STATUS, REG_CTRL: addr_ok = 1'b1;
            default:                        addr_ok = 1'b0;
        endcase
    end

    assign data_wr   = access && apb_req.pwrite && (apb_req.paddr == REG_DATA);
    assign data_rd   = access && !apb_req.pwrite && (apb_req.paddr == REG_DATA);
    assign status_wr = access && apb_req.pwrite && (apb_req.paddr == REG_STATUS);
    assign ctrl_wr   = access && apb_req.pwrite && (apb_req.paddr == REG_CTRL);

    // a data write is offered to the transmitter and completes with its ready.
    assign tx_valid = data_wr;
    assign tx_data  = apb_req.pwdata[7:0];

    assign apb_rsp.pready  = access && (!data_wr || tx_ready);
    assign apb_rsp.pslverr = access && !addr_ok; // unknown addresses never stall.

    // ======================================================================
    // read data
    // ======================================================================

    always_comb begin
        status                   = '0;
        status[status_tx_ready]  = tx_ready;
        status[status_rx_valid]  = stat_rx_valid;
        status[status_overrun]   = stat_overrun;
        status[status_frame_err] = stat_frame_err;
    end

    always_comb begin
        case (apb_req.paddr)
            REG_DATA:   apb_rsp.prdata = {24'd0, rx_data};
            REG_STATUS: apb_rsp.prdata = {28'd0, status};
            REG_CTRL:   apb_rsp.prdata = {31'd0, loopback};
            default:    apb_rsp.prdata = 32'd0;
        endcase
    end

    // ======================================================================
    // receive data and sticky flags
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rx_valid) begin
            rx_data <= rx_frame.data;           // a new byte replaces an unread one.
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stat_rx_valid  <= 1'b0;
            stat_overrun   <= 1'b0;
            stat_frame_err <= 1'b0;
            loopback       <= 1'b0;
        end else begin
            // reading the data register consumes the byte and clears the overrun.
            if (data_rd) begin
                stat_rx_valid <= 1'b0;
                stat_overrun  <= 1'b0;
            end
            if (status_wr && apb_req.pwdata[status_overrun]) begin
                stat_overrun <= 1'b0;           // write one to clear.
            end
            if (status_wr && apb_req.pwdata[status_frame_err]) begin
                stat_frame_err <= 1'b0;         // write one to clear.
            end
            // a new frame wins over a clear in the same cycle.
            if (rx_valid) begin
                stat_rx_valid <= 1'b1;
                if (stat_rx_valid && !data_rd) begin
                    stat_overrun <= 1'b1;       // old byte lost without a read.
                end
                if (rx_frame.frame_err) begin
                    stat_frame_err <= 1'b1;
                end
            end
            if (ctrl_wr) begin
                loopback <= apb_req.pwdata[0];
            end
        end
    end

endmodule

//--- src/uart_apb_top.sv
`timescale 1ns/1ps

module uart_apb_top import uart_pkg::*; #(
    parameter int clk_freq  = 125_000_000,
    parameter int baud_rate = 12_500_000
) (
    input  logic     clk,
    input  logic     resetn,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  logic     rxd,
    output logic     txd
);

    logic       tx_valid;  // register block offers a byte.
    logic [7:0] tx_data;
    logic       tx_ready;  // transmitter is idle.
    logic       rx_valid;  // receiver pulses once per frame.
    rx_frame_t  rx_frame;
    logic       loopback;  // control bit from the register block.
    logic       rx_line;   // line seen by the receiver.

    // in loopback the receiver listens to our own transmitter.
    assign rx_line = loopback ? txd : rxd;

    // ======================================================================
    // register block and serial engines
    // ======================================================================

    uart_apb_regs u_regs (
        .clk      (clk),
        .resetn   (resetn),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .rx_valid (rx_valid),
        .rx_frame (rx_frame),
        .loopback (loopback)
    );

    uart_tx #(
        .clk_freq  (clk_freq),
        .baud_rate (baud_rate)
    ) u_tx (
        .clk      (clk),
        .resetn   (resetn),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .tx_ready (tx_ready),
        .txd      (txd)
    );

    uart_rx #(
        .clk_freq  (clk_freq),
        .baud_rate (baud_rate)
    ) u_rx (
        .clk      (clk),
        .resetn   (resetn),
        .rxd      (rx_line),
        .rx_valid (rx_valid),
        .rx_frame (rx_frame)
    );

endmodule

//--- verification/uart_props.sv
`timescale 1ns/1ps

module uart_props import uart_pkg::*; (
    input logic     clk,
    input logic     resetn,
    input apb_req_t apb_req,
    input apb_rsp_t apb_rsp,
    input logic     tx_ready,
    input logic     txd
);

    // an idle transmitter keeps the line at the stop level.
    assert property (@(posedge clk) disable iff (!resetn) tx_ready |-> txd)
        else $error("txd is low while the transmitter reports ready");

    // an error response only comes on the completing cycle.
    assert property (@(posedge clk) disable iff (!resetn) apb_rsp.pslverr |-> apb_rsp.pready)
        else $error("pslverr raised without pready");

    // a stalled access phase keeps the whole request unchanged.
    assert property (@(posedge clk) disable iff (!resetn)
        (apb_req.psel && apb_req.penable && !apb_rsp.pready) |=> $stable(apb_req))
        else $error("APB request changed while pready was low");

    // setup is always followed by the access phase of the same transfer.
    assert property (@(posedge clk) disable iff (!resetn)
        (apb_req.psel && !apb_req.penable) |=>
            (apb_req.psel && apb_req.penable && $stable(apb_req.paddr)
             && $stable(apb_req.pwrite) && $stable(apb_req.pwdata)))
        else $error("APB setup phase not followed by a matching access phase");

endmodule

bind uart_apb_top uart_props u_props (
    .clk      (clk),
    .resetn   (resetn),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .tx_ready (tx_ready),
    .txd      (txd)
);

//--- verification/uart_tb.sv
`timescale 1ns/1ps

module uart_tb import uart_pkg::*;;

    localparam int clk_freq       = 125_000_000;
    localparam int baud_rate      = 12_500_000;
    localparam int cycles_per_bit = clk_freq / baud_rate;
    localparam int clk_ns         = 8;
    localparam int bit_ns         = cycles_per_bit * clk_ns;
    localparam int frame_ns       = 10 * bit_ns;       // start, eight data bits, stop.
    localparam int num_tests      = 12;

    typedef enum {T_IDLE, T_TX, T_BP, T_RX, T_OVR, T_ADDR} test_kind_e;

    typedef struct {
        string      name;
        test_kind_e kind;
        logic [7:0] data;       // byte to send, replaced by an lcg byte when flags[2] is set.
        logic [2:0] flags;      // [0] loopback, [1] low stop bit, [2] random byte.
        logic [3:0] exp_status; // status expected once the stimulus has settled.
    } test_t;

    logic        clk;
    logic        resetn;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        rxd;
    logic        txd;
    test_t       tests [num_tests];
    logic [7:0]  exp_tx [$];                            // bytes still due on txd, in order.
    logic [31:0] lcg_state = 32'h9284fb58;
    string       cur_name = "startup";
    int          check_count = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    uart_apb_top #(.clk_freq(clk_freq), .baud_rate(baud_rate)) UUT (
        .clk     (clk),
        .resetn  (resetn),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .rxd     (rxd),
        .txd     (txd)
    );

    // ======================================================================
    // clock, watchdog and helpers
    // ======================================================================

    initial begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~clk;
    end

    initial begin
        #(num_tests * 25 * frame_ns);                   // 25 frame times per table entry.
        $display("watchdog expired after %0d ns, the run is stuck", num_tests * 25 * frame_ns);
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_test(input int idx, input string name, input test_kind_e kind,
                            input logic [7:0] data, input logic [2:0] flags,
                            input logic [3:0] exp_status);
        tests[idx] = '{name, kind, data, flags, exp_status};
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        check_count++;
        if (act !== exp) begin
            value_errors++;
            $display("** Error [%s]: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            value_errors++;
            $display("** Error [%s]: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_frame(input string name, input rx_frame_t exp, input rx_frame_t act);
        check_count++;
        if (act !== exp) begin
            value_errors++;
            $display("** Error [%s]: expected data %h err %b, actual data %h err %b",
                     name, exp.data, exp.frame_err, act.data, act.frame_err);
        end
    endtask

    // setup phase, then access phase held until pready; inputs change on the falling edge.
    task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err, output time done_at);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(clk_ns / 4);                                  // outputs settled in the low phase.
        while (!apb_rsp.pready) begin
            @(negedge clk);
            #(clk_ns / 4);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        done_at = $time;                                // transfer completes on this edge.
        @(negedge clk);
        apb_req = '0;
    endtask

    // polls the status register until every bit in mask is set.
    task automatic wait_status(input logic [3:0] mask, output logic [31:0] st);
        logic err;
        time  t;
        int   polls;
        polls = 0;
        do begin
            apb_access(1'b0, REG_STATUS, 32'd0, st, err, t);
            polls++;
        end while ((st[3:0] & mask) != mask && polls < 400);
        if ((st[3:0] & mask) != mask) begin
            other_errors++;
            $display("%s: status bits %b never came up, last status %h", cur_name, mask, st);
        end
    endtask

    // one 8N1 frame on rxd followed by one idle bit.
    task automatic send_frame(input logic [7:0] data, input logic stop_level);
        logic [9:0] bits;
        bits = {stop_level, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rxd = bits[i];
            repeat (cycles_per_bit - 1) @(negedge clk);
        end
        @(negedge clk);
        rxd = 1'b1;
        repeat (cycles_per_bit - 1) @(negedge clk);
    endtask

    // samples every frame on txd at its bit centers and matches it to the queue.
    initial begin : txd_monitor
        logic [7:0] frame_byte;
        logic       start_bit;
        logic       stop_bit;
        wait (resetn === 1'b1);
        forever begin
            @(negedge txd);
            #(bit_ns / 2 + clk_ns / 2);                 // middle of the start bit.
            start_bit = txd;
            for (int i = 0; i < 8; i++) begin
                #(bit_ns);
                frame_byte[i] = txd;                    // lsb first.
            end
            #(bit_ns);
            stop_bit = txd;
            if (start_bit !== 1'b0 || stop_bit !== 1'b1) begin
                other_errors++;
                $display("%s: bad framing on txd, start %b stop %b", cur_name, start_bit, stop_bit);
            end
            if (exp_tx.size() == 0) begin
                other_errors++;
                $display("%s: frame %h on txd that nobody wrote", cur_name, frame_byte);
            end else begin
                check_byte({cur_name, " txd"}, exp_tx.pop_front(), frame_byte);
            end
        end
    end

    // ======================================================================
    // stimulus table and main sequence
    // ======================================================================

    initial begin
        logic [31:0] rd;
        logic [31:0] st;
        logic        er;
        time         t1;
        time         t2;
        logic [7:0]  data;
        rx_frame_t   exp_f;
        rx_frame_t   act_f;
        test_t       t;

        resetn  = 1'b0;
        rxd     = 1'b1;                                 // serial line idles high.
        apb_req = '0;

        add_test(0,  "reset_values",  T_IDLE, 8'h00, 3'b000, 4'h1);
        add_test(1,  "tx_a5",         T_TX,   8'hA5, 3'b000, 4'h1);
        add_test(2,  "tx_01",         T_TX,   8'h01, 3'b000, 4'h1);
        add_test(3,  "tx_random_0",   T_TX,   8'h00, 3'b100, 4'h1);
        add_test(4,  "tx_random_1",   T_TX,   8'h00, 3'b100, 4'h1);
        add_test(5,  "back_pressure", T_BP,   8'h3C, 3'b000, 4'h1);
        add_test(6,  "rx_5a",         T_RX,   8'h5A, 3'b000, 4'h3);
        add_test(7,  "rx_random",     T_RX,   8'h00, 3'b100, 4'h3);
        add_test(8,  "rx_overrun",    T_OVR,  8'hC3, 3'b000, 4'h7);
        add_test(9,  "frame_error",   T_RX,   8'h96, 3'b010, 4'hB);
        add_test(10, "bad_address",   T_ADDR, 8'h00, 3'b000, 4'h1);
        add_test(11, "loopback",      T_RX,   8'h7E, 3'b001, 4'h3);

        repeat (4) @(negedge clk);
        resetn = 1'b1;

        for (int i = 0; i < num_tests; i++) begin
            t        = tests[i];
            cur_name = t.name;
            data     = t.data;
            if (t.flags[2]) begin
                lcg_state = lcg_next(lcg_state);
                data      = lcg_state[23:16];
            end
            case (t.kind)
                T_IDLE: begin
                    apb_access(1'b0, REG_STATUS, 32'd0, st, er, t1);
                    check_word(t.name, {28'd0, t.exp_status}, st);
                    apb_access(1'b0, REG_CTRL, 32'd0, rd, er, t1);
                    check_word(t.name, 32'd0, rd);
                    check_byte(t.name, 8'h01, {7'd0, txd});
                end
                T_TX: begin
                    exp_tx.push_back(data);
                    apb_access(1'b1, REG_DATA, {24'd0, data}, rd, er, t1);
                    wait_status(4'h1, st);              // idle again after the stop bit.
                    check_word(t.name, {28'd0, t.exp_status}, st);
                end
                T_BP: begin
                    exp_tx.push_back(data);
                    exp_tx.push_back(~data);
                    apb_access(1'b1, REG_DATA, {24'd0, data}, rd, er, t1);
                    apb_access(1'b1, REG_DATA, {24'd0, ~data}, rd, er, t2);
                    check_count++;
                    if (t2 - t1 < frame_ns) begin
                        other_errors++;
                        $display("%s: second write finished %0t after the first, before the frame",
                                 t.name, t2 - t1);
                    end
                    wait_status(4'h1, st);
                    check_word(t.name, {28'd0, t.exp_status}, st);
                end
                T_RX: begin
                    if (t.flags[0]) begin
                        apb_access(1'b1, REG_CTRL, 32'd1, rd, er, t1);
                        @(negedge clk);
                        rxd = 1'b0;                     // must not reach the receiver.
                        exp_tx.push_back(data);
                        apb_access(1'b1, REG_DATA, {24'd0, data}, rd, er, t1);
                    end else begin
                        send_frame(data, !t.flags[1]);
                    end
                    wait_status(4'h3, st);
                    check_word(t.name, {28'd0, t.exp_status}, st);
                    apb_access(1'b0, REG_DATA, 32'd0, rd, er, t1);
                    exp_f.data      = data;
                    exp_f.frame_err = t.flags[1];
                    act_f.data      = rd[7:0];
                    act_f.frame_err = st[status_frame_err];
                    check_frame(t.name, exp_f, act_f);
                    apb_access(1'b0, REG_STATUS, 32'd0, st, er, t1);
                    check_word(t.name, {28'd0, t.exp_status & 4'b1001}, st); // read consumed it.
                    if (t.flags[1]) begin
                        apb_access(1'b1, REG_STATUS, 32'h8, rd, er, t1);
                        apb_access(1'b0, REG_STATUS, 32'd0, st, er, t1);
                        check_word(t.name, 32'h1, st);
                    end
                    if (t.flags[0]) begin
                        @(negedge clk);
                        rxd = 1'b1;
                        apb_access(1'b1, REG_CTRL, 32'd0, rd, er, t1);
                    end
                end
                T_OVR: begin
                    send_frame(data, 1'b1);
                    send_frame(~data, 1'b1);            // lands on the unread first byte.
                    wait_status(4'h3, st);
                    check_word(t.name, {28'd0, t.exp_status}, st);
                    apb_access(1'b0, REG_DATA, 32'd0, rd, er, t1);
                    check_byte(t.name, ~data, rd[7:0]);
                    apb_access(1'b0, REG_STATUS, 32'd0, st, er, t1);
                    check_word(t.name, 32'h1, st);
                end
                T_ADDR: begin
                    apb_access(1'b0, 4'hC, 32'd0, rd, er, t1);
                    check_byte(t.name, 8'h01, {7'd0, er});
                    apb_access(1'b0, REG_STATUS, 32'd0, st, er, t1);
                    check_word(t.name, {28'd0, t.exp_status}, st);
                end
                default: ;
            endcase
        end

        if (exp_tx.size() != 0) begin
            other_errors++;
            $display("%0d written bytes never appeared on txd", exp_tx.size());
        end
        $display("checks: %0d, value errors: %0d, other failures: %0d",
                 check_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- list.f
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_apb_regs.sv
src/uart_apb_top.sv
verification/uart_props.sv
verification/uart_tb.sv

//--- Bender.yml
package:
  name: uart_apb

dependencies: {}

sources:
  - src/uart_pkg.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/uart_apb_regs.sv
  - src/uart_apb_top.sv

  - target: test
    files:
      - verification/uart_props.sv
      - verification/uart_tb.sv
